// ==== sources.f ====
+incdir+verif
hw/rv_core_pkg.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_id_stage.sv
hw/rv_ex_stage.sv
hw/rv_core_top.sv
verif/tb_rv_core_top.sv

// ==== verif/rv_core_model.svh ====
`ifndef RV_CORE_MODEL_SVH
`define RV_CORE_MODEL_SVH

// Architectural register state where x0 stays zero because nothing writes it
word_t   model_regs [NUM_REGS] = '{default: '0};
retire_t exp_q [$];
int      due_q [$];
int      error_count = 0;

// Result as the RV32I spec defines it for each funct3
function automatic word_t alu_result(logic [2:0] f3, logic alt, word_t a, word_t b);
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b001:  return a << b[4:0];
        3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011:  return (a < b) ? 32'd1 : 32'd0;
        3'b100:  return a ^ b;
        3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

task automatic predict_retire(input fetch_t slot, output retire_t want);
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       alt;
    logic       legal;
    word_t      a;
    word_t      b;
    opc   = slot.inst[6:0];
    f3    = slot.inst[14:12];
    f7    = slot.inst[31:25];
    alt   = (f7 == 7'h20);
    legal = 1'b1;
    a     = model_regs[slot.inst[19:15]];
    b     = model_regs[slot.inst[24:20]];
    case (opc)
        OPC_OP: begin
            legal = (f7 == 7'h00) || (alt && (f3 == 3'b000 || f3 == 3'b101));
        end
        OPC_OP_IMM: begin
            b   = {{20{slot.inst[31]}}, slot.inst[31:20]};
            alt = alt && (f3 == 3'b101);
            if (f3 == 3'b001 || f3 == 3'b101) begin
                legal = (f7 == 7'h00) || alt;
            end
        end
        OPC_LUI, OPC_AUIPC: begin
            // Upper immediate lands on zero or on the instruction's own pc
            a   = (opc == OPC_LUI) ? '0 : slot.pc;
            b   = {slot.inst[31:12], 12'h000};
            f3  = 3'b000;
            alt = 1'b0;
        end
        default: legal = 1'b0;
    endcase
    want.valid   = 1'b1;
    want.illegal = !legal;
    want.pc      = slot.pc;
    want.rd      = slot.inst[11:7];
    want.we      = legal && (want.rd != 0);
    want.wdata   = alu_result(f3, alt, a, b);
    if (want.we) begin
        model_regs[want.rd] = want.wdata;
    end
endtask

task automatic check_retire(input retire_t got, input retire_t want);
    if (got.valid !== want.valid || got.illegal !== want.illegal || got.pc !== want.pc ||
        got.rd !== want.rd || got.we !== want.we ||
        (!want.illegal && got.wdata !== want.wdata)) begin
        $display("[ERROR] %0t: pc %h retired rd %0d we %b ill %b data %h, want %0d %b %b %h",
                 $time, want.pc, got.rd, got.we, got.illegal, got.wdata,
                 want.rd, want.we, want.illegal, want.wdata);
        error_count++;
    end
endtask

task automatic check_count(input int got, input int want, input string what);
    if (got != want) begin
        $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, want);
        error_count++;
    end
endtask

`endif

// ==== verif/tb_rv_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core_top;

    import rv_core_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int SEED        = 44;
    localparam int N_ALU       = 400;
    localparam int N_FWD       = 150;
    localparam int N_X0        = 100;
    localparam int TOTAL_SLOTS = 3 + 4 + 62 + N_ALU + N_FWD + N_X0 + 5 * 3;

    logic    clk_i;
    logic    rst_n_i;
    fetch_t  fetch_i;
    retire_t retire_o;
    word_t   pc_next = 32'h0000_1000;
    int      cycle_count = 0;
    int      issued_count = 0;
    int      retired_count = 0;
    int      iss_mark = 0;
    int      ret_mark = 0;
    int      err_mark = 0;
    int      seed_state;

    `include "rv_core_model.svh"

    rv_core_top rv_core_top_i (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .fetch_i  (fetch_i),
        .retire_o (retire_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        #(CLK_PERIOD * (TOTAL_SLOTS + 100));
        $display("Timeout: the run did not finish within %0d cycles", TOTAL_SLOTS + 100);
        $display("Regression failed");
        $finish;
    end

    // Retires must come back in issue order, two edges after their slot
    always @(negedge clk_i) begin : retire_monitor
        retire_t want;
        if (rst_n_i && retire_o.valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("A result retired at %0t with no instruction in flight", $time);
                error_count++;
            end else begin
                want = exp_q.pop_front();
                check_retire(retire_o, want);
                check_count(cycle_count, due_q.pop_front(), "retire cycle");
                retired_count++;
            end
        end
    end

    function automatic reg_addr_t pick_reg();
        return ($urandom_range(0, 9) == 0) ? 5'($urandom) : 5'($urandom_range(0, 7));
    endfunction

    function automatic word_t illegal_inst(reg_addr_t rd);
        case ($urandom_range(0, 4))
            0:       return {12'($urandom), 5'd1, 3'b010, rd, 7'b0000011};
            1:       return {20'($urandom), rd, 7'b1101111};
            2:       return {7'h01, 5'd2, 5'd3, 3'b000, rd, OPC_OP};
            3:       return {7'h20, 5'd4, 5'd1, 3'b001, rd, OPC_OP_IMM};
            default: return {7'h20, 5'd2, 5'd1, 3'b110, rd, OPC_OP};
        endcase
    endfunction

    function automatic word_t random_inst(reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2);
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        f3  = 3'($urandom_range(0, 7));
        f7  = ((f3 == 3'b000 || f3 == 3'b101) && $urandom_range(0, 1) == 1) ? 7'h20 : 7'h00;
        imm = 12'($urandom);
        // Shift immediates carry funct7 in the upper immediate bits
        if (f3 == 3'b001 || f3 == 3'b101) begin
            imm[11:5] = f7;
        end
        case ($urandom_range(0, 11))
            0, 1, 2, 3, 4: return {f7, rs2, rs1, f3, rd, OPC_OP};
            5, 6, 7, 8:    return {imm, rs1, f3, rd, OPC_OP_IMM};
            9:             return {20'($urandom), rd, OPC_LUI};
            10:            return {20'($urandom), rd, OPC_AUIPC};
            default:       return illegal_inst(rd);
        endcase
    endfunction

    task automatic issue_slot(input logic valid, input word_t inst);
        retire_t want;
        @(negedge clk_i);
        fetch_i.valid = valid;
        fetch_i.pc    = pc_next;
        fetch_i.inst  = inst;
        if (valid) begin
            predict_retire(fetch_i, want);
            exp_q.push_back(want);
            due_q.push_back(cycle_count + 2);
            issued_count++;
            pc_next += 4;
        end
    endtask

    // Three bubbles cover the two-edge latency of the last slot
    task automatic end_test(input string name);
        repeat (3) issue_slot(1'b0, '0);
        if (exp_q.size() != 0) begin
            $display("%0d instructions of test %s never retired", exp_q.size(), name);
            error_count++;
            exp_q.delete();
            due_q.delete();
        end
        check_count(retired_count - ret_mark, issued_count - iss_mark, {name, " retires"});
        $display("test %-9s %4d issued, %0d errors", name, issued_count - iss_mark,
                 error_count - err_mark);
        iss_mark = issued_count;
        ret_mark = retired_count;
        err_mark = error_count;
    endtask

    initial begin
        reg_addr_t rd;
        reg_addr_t prev1;
        reg_addr_t prev2;
        seed_state = $urandom(SEED);
        // A valid slot held during reset must be flushed and never retire
        fetch_i       = '0;
        fetch_i.valid = 1'b1;
        fetch_i.inst  = {12'd1, 5'd0, 3'b000, 5'd1, OPC_OP_IMM};
        rst_n_i       = 1'b0;
        prev1         = 5'd1;
        prev2         = 5'd2;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        fetch_i = '0;
        repeat (4) begin
            @(negedge clk_i);
            check_count((retire_o.valid === 1'b0) ? 0 : 1, 0, "idle retire valid");
        end
        end_test("reset");
        for (int r = 1; r < NUM_REGS; r++) begin
            issue_slot(1'b1, {20'($urandom), 5'(r), OPC_LUI});
            issue_slot(1'b1, {12'($urandom), 5'(r), 3'b000, 5'(r), OPC_OP_IMM});
        end
        end_test("preamble");
        for (int i = 0; i < N_ALU; i++) begin
            issue_slot($urandom_range(0, 4) != 0, random_inst(pick_reg(), pick_reg(), pick_reg()));
        end
        end_test("alu");
        for (int i = 0; i < N_FWD; i++) begin
            rd = 5'($urandom_range(1, 7));
            issue_slot(1'b1, random_inst(rd, $urandom_range(0, 1) ? prev1 : prev2, prev1));
            prev2 = prev1;
            prev1 = rd;
        end
        end_test("forward");
        for (int i = 0; i < N_X0; i++) begin
            case ($urandom_range(0, 3))
                0:       issue_slot(1'b1, random_inst(5'd0, pick_reg(), pick_reg()));
                1:       issue_slot(1'b1, random_inst(pick_reg(), 5'd0, 5'd0));
                2:       issue_slot(1'b1, illegal_inst(pick_reg()));
                default: issue_slot(1'b1, random_inst(pick_reg(), pick_reg(), pick_reg()));
            endcase
        end
        end_test("x0_illegal");
        $display("Totals: %0d issued, %0d retired, %0d errors", issued_count, retired_count,
                 error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/rv_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_top (
    input  wire                         clk_i,
    input  wire                         rst_n_i,
    input  wire rv_core_pkg::fetch_t    fetch_i,
    output rv_core_pkg::retire_t        retire_o
);

    import rv_core_pkg::*;

    id_ex_t    id_ex;
    retire_t   ex_fwd;
    retire_t   retire;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;

    rv_id_stage rv_id_stage_i (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .fetch_i    (fetch_i),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .ex_fwd_i   (ex_fwd),
        .retire_i   (retire),
        .id_ex_o    (id_ex)
    );

    rv_ex_stage rv_ex_stage_i (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .id_ex_i  (id_ex),
        .ex_fwd_o (ex_fwd),
        .retire_o (retire)
    );

    // Register file is written from the retiring result
    rv_regfile rv_regfile_i (
        .clk_i     (clk_i),
        .raddr_a_i (rs1_addr),
        .raddr_b_i (rs2_addr),
        .rdata_a_o (rs1_data),
        .rdata_b_o (rs2_data),
        .wr_i      (retire)
    );

    assign retire_o = retire;

endmodule

`default_nettype wire

// ==== hw/rv_ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_ex_stage (
    input  wire                         clk_i,
    input  wire                         rst_n_i,
    input  wire rv_core_pkg::id_ex_t    id_ex_i,
    output rv_core_pkg::retire_t        ex_fwd_o,
    output rv_core_pkg::retire_t        retire_o
);

    import rv_core_pkg::*;

    word_t      op_a;
    word_t      op_b;
    logic [4:0] shamt;
    word_t      result;
    retire_t    retire_q;

    assign op_a  = id_ex_i.op_a;
    assign op_b  = id_ex_i.op_b;
    assign shamt = op_b[4:0];

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_ADD:  result = op_a + op_b;
            ALU_SUB:  result = op_a - op_b;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_AND:  result = op_a & op_b;
            ALU_OR:   result = op_a | op_b;
            ALU_XOR:  result = op_a ^ op_b;
            ALU_SLL:  result = op_a << shamt;
            ALU_SRL:  result = op_a >> shamt;
            ALU_SRA:  result = word_t'($signed(op_a) >>> shamt);
            default:  result = '0;
        endcase
    end

    // Seen by decode in the same cycle for back-to-back dependencies
    always_comb begin
        ex_fwd_o.valid   = id_ex_i.valid;
        ex_fwd_o.illegal = id_ex_i.illegal;
        ex_fwd_o.pc      = id_ex_i.pc;
        ex_fwd_o.rd      = id_ex_i.rd;
        ex_fwd_o.we      = id_ex_i.we;
        ex_fwd_o.wdata   = result;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            retire_q.valid <= 1'b0;
            retire_q.we    <= 1'b0;
        end else begin
            retire_q.valid <= ex_fwd_o.valid;
            retire_q.we    <= ex_fwd_o.we;
        end
    end

    always_ff @(posedge clk_i) begin
        retire_q.illegal <= ex_fwd_o.illegal;
        retire_q.pc      <= ex_fwd_o.pc;
        retire_q.rd      <= ex_fwd_o.rd;
        retire_q.wdata   <= ex_fwd_o.wdata;
    end

    assign retire_o = retire_q;

endmodule

`default_nettype wire

// ==== hw/rv_id_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_id_stage (
    input  wire                          clk_i,
    input  wire                          rst_n_i,
    input  wire rv_core_pkg::fetch_t     fetch_i,
    output rv_core_pkg::reg_addr_t       rs1_addr_o,
    output rv_core_pkg::reg_addr_t       rs2_addr_o,
    input  wire rv_core_pkg::word_t      rs1_data_i,
    input  wire rv_core_pkg::word_t      rs2_data_i,
    input  wire rv_core_pkg::retire_t    ex_fwd_i,
    input  wire rv_core_pkg::retire_t    retire_i,
    output rv_core_pkg::id_ex_t          id_ex_o
);

    import rv_core_pkg::*;

    alu_op_e   alu_op;
    reg_addr_t rd;
    logic      use_rs1;
    logic      use_rs2;
    logic      pc_rel;
    logic      we;
    logic      illegal;
    word_t     imm;
    word_t     rs1_val;
    word_t     rs2_val;
    id_ex_t    id_ex_d;
    id_ex_t    id_ex_q;

    rv_decoder rv_decoder_i (
        .inst_i    (fetch_i.inst),
        .alu_op_o  (alu_op),
        .rd_o      (rd),
        .rs1_o     (rs1_addr_o),
        .rs2_o     (rs2_addr_o),
        .use_rs1_o (use_rs1),
        .use_rs2_o (use_rs2),
        .pc_rel_o  (pc_rel),
        .we_o      (we),
        .illegal_o (illegal),
        .imm_o     (imm)
    );

    // Youngest producer wins, then the one retiring, then the register file
    function automatic word_t fwd_value(reg_addr_t addr, word_t rf_data,
                                        retire_t ex, retire_t ret);
        word_t val;
        val = rf_data;
        if (ex.valid && ex.we && (ex.rd == addr)) begin
            val = ex.wdata;
        end else if (ret.valid && ret.we && (ret.rd == addr)) begin
            val = ret.wdata;
        end
        return val;
    endfunction

    assign rs1_val = fwd_value(rs1_addr_o, rs1_data_i, ex_fwd_i, retire_i);
    assign rs2_val = fwd_value(rs2_addr_o, rs2_data_i, ex_fwd_i, retire_i);

    always_comb begin
        id_ex_d.valid   = fetch_i.valid;
        id_ex_d.illegal = illegal;
        id_ex_d.alu_op  = alu_op;
        id_ex_d.pc      = fetch_i.pc;
        id_ex_d.rd      = rd;
        id_ex_d.we      = fetch_i.valid & we;
        // LUI reaches the ALU as 0 + imm
        if (use_rs1) begin
            id_ex_d.op_a = rs1_val;
        end else if (pc_rel) begin
            id_ex_d.op_a = fetch_i.pc;
        end else begin
            id_ex_d.op_a = '0;
        end
        id_ex_d.op_b = use_rs2 ? rs2_val : imm;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            id_ex_q.valid <= 1'b0;
            id_ex_q.we    <= 1'b0;
        end else begin
            id_ex_q.valid <= id_ex_d.valid;
            id_ex_q.we    <= id_ex_d.we;
        end
    end

    always_ff @(posedge clk_i) begin
        id_ex_q.illegal <= id_ex_d.illegal;
        id_ex_q.alu_op  <= id_ex_d.alu_op;
        id_ex_q.pc      <= id_ex_d.pc;
        id_ex_q.rd      <= id_ex_d.rd;
        id_ex_q.op_a    <= id_ex_d.op_a;
        id_ex_q.op_b    <= id_ex_d.op_b;
    end

    assign id_ex_o = id_ex_q;

endmodule

`default_nettype wire

// ==== hw/rv_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
    input  wire                         clk_i,
    input  wire rv_core_pkg::reg_addr_t raddr_a_i,
    input  wire rv_core_pkg::reg_addr_t raddr_b_i,
    output rv_core_pkg::word_t          rdata_a_o,
    output rv_core_pkg::word_t          rdata_b_o,
    input  wire rv_core_pkg::retire_t   wr_i
);

    import rv_core_pkg::*;

    // No storage behind x0
    word_t regs [1:NUM_REGS-1];

    always_ff @(posedge clk_i) begin
        if (wr_i.valid && wr_i.we && (wr_i.rd != '0)) begin
            regs[wr_i.rd] <= wr_i.wdata;
        end
    end

    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

`default_nettype wire

// ==== hw/rv_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
    input  wire rv_core_pkg::word_t   inst_i,
    output rv_core_pkg::alu_op_e      alu_op_o,
    output rv_core_pkg::reg_addr_t    rd_o,
    output rv_core_pkg::reg_addr_t    rs1_o,
    output rv_core_pkg::reg_addr_t    rs2_o,
    output logic                      use_rs1_o,
    output logic                      use_rs2_o,
    output logic                      pc_rel_o,
    output logic                      we_o,
    output logic                      illegal_o,
    output rv_core_pkg::word_t        imm_o
);

    import rv_core_pkg::*;

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic        f7_base;
    logic        f7_alt;
    word_t       i_imm;
    word_t       u_imm;
    word_t       shamt_imm;
    logic        legal;

    assign funct3    = inst_i[14:12];
    assign funct7    = inst_i[31:25];
    assign f7_base   = (funct7 == 7'b0000000);
    assign f7_alt    = (funct7 == 7'b0100000);
    assign i_imm     = {{(XLEN-12){inst_i[31]}}, inst_i[31:20]};
    assign u_imm     = {inst_i[31:12], 12'h000};
    assign shamt_imm = {{(XLEN-5){1'b0}}, inst_i[24:20]};

    assign rd_o  = inst_i[11:7];
    assign rs1_o = inst_i[19:15];
    assign rs2_o = inst_i[24:20];

    always_comb begin
        alu_op_o  = ALU_ADD;
        use_rs1_o = 1'b0;
        use_rs2_o = 1'b0;
        pc_rel_o  = 1'b0;
        imm_o     = '0;
        legal     = 1'b0;
        case (inst_i[6:0])
            OPC_OP: begin
                use_rs1_o = 1'b1;
                use_rs2_o = 1'b1;
                legal     = f7_base;
                case (funct3)
                    F3_ADD: begin
                        alu_op_o = f7_alt ? ALU_SUB : ALU_ADD;
                        legal    = f7_base | f7_alt;
                    end
                    F3_SRL: begin
                        alu_op_o = f7_alt ? ALU_SRA : ALU_SRL;
                        legal    = f7_base | f7_alt;
                    end
                    F3_SLL:  alu_op_o = ALU_SLL;
                    F3_SLT:  alu_op_o = ALU_SLT;
                    F3_SLTU: alu_op_o = ALU_SLTU;
                    F3_XOR:  alu_op_o = ALU_XOR;
                    F3_OR:   alu_op_o = ALU_OR;
                    F3_AND:  alu_op_o = ALU_AND;
                endcase
            end
            OPC_OP_IMM: begin
                use_rs1_o = 1'b1;
                imm_o     = i_imm;
                legal     = 1'b1;
                case (funct3)
                    F3_SLL: begin
                        alu_op_o = ALU_SLL;
                        imm_o    = shamt_imm;
                        legal    = f7_base;
                    end
                    F3_SRL: begin
                        // SRAI is told apart from SRLI by bit 30 only
                        alu_op_o = f7_alt ? ALU_SRA : ALU_SRL;
                        imm_o    = shamt_imm;
                        legal    = f7_base | f7_alt;
                    end
                    F3_ADD:  alu_op_o = ALU_ADD;
                    F3_SLT:  alu_op_o = ALU_SLT;
                    F3_SLTU: alu_op_o = ALU_SLTU;
                    F3_XOR:  alu_op_o = ALU_XOR;
                    F3_OR:   alu_op_o = ALU_OR;
                    F3_AND:  alu_op_o = ALU_AND;
                endcase
            end
            OPC_LUI: begin
                imm_o = u_imm;
                legal = 1'b1;
            end
            OPC_AUIPC: begin
                pc_rel_o = 1'b1;
                imm_o    = u_imm;
                legal    = 1'b1;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    // Writes to x0 are dropped here so later stages never see them
    assign we_o      = legal && (rd_o != '0);
    assign illegal_o = ~legal;

endmodule

`default_nettype wire

// ==== hw/rv_core_pkg.sv ====
`default_nettype none

package rv_core_pkg;

    // Widths fixed by the RV32I instruction format
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 2 ** REG_ADDR_W;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Major opcodes handled by this core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9
    } alu_op_e;

    // One instruction slot from fetch
    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t inst;
    } fetch_t;

    // Decoded instruction with its operands already resolved
    typedef struct packed {
        logic      valid;
        logic      illegal;
        alu_op_e   alu_op;
        word_t     pc;
        reg_addr_t rd;
        logic      we;
        word_t     op_a;
        word_t     op_b;
    } id_ex_t;

    // Result of execute, also used as a forwarding source
    typedef struct packed {
        logic      valid;
        logic      illegal;
        word_t     pc;
        reg_addr_t rd;
        logic      we;
        word_t     wdata;
    } retire_t;

endpackage

`default_nettype wire
